/* Bender.yml */
package:
  name: lcd_driver

sources:
  - source/lcdPkg.sv
  - source/lcdStepTimer.sv
  - source/lcdSequencer.sv
  - source/lcdNibbleWriter.sv
  - source/lcdDriver.sv
  - target: simulation
    files:
      - tb/lcdDriverTb.sv

/* files.f */
source/lcdPkg.sv
source/lcdStepTimer.sv
source/lcdSequencer.sv
source/lcdNibbleWriter.sv
source/lcdDriver.sv
tb/lcdDriverTb.sv

/* source/lcdDriver.sv */
module lcdDriver #(
    parameter int stepCycles = lcdPkg::defaultStepCycles,
    parameter int gapSteps   = lcdPkg::defaultGapSteps
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [lcdPkg::lineBits-1:0] lineA,
    input  logic [lcdPkg::lineBits-1:0] lineB,
    output logic                        lcdE,
    output logic                        lcdRw,
    output logic                        lcdRs,
    output lcdPkg::nibbleT              lcdData
);
    import lcdPkg::*;

    logic     tick;
    logic     ready;
    logic     issue;
    byteT     itemByte;
    itemKindT itemKind;

    // write only, the busy flag is never read
    assign lcdRw = 1'b0;

    lcdStepTimer #(
        .stepCycles(stepCycles)
    ) i_lcdStepTimer (
        .clk (clk),
        .rstN(rstN),
        .tick(tick)
    );

    lcdSequencer #(
        .gapSteps(gapSteps)
    ) i_lcdSequencer (
        .clk     (clk),
        .rstN    (rstN),
        .tick    (tick),
        .ready   (ready),
        .lineA   (lineA),
        .lineB   (lineB),
        .issue   (issue),
        .itemByte(itemByte),
        .itemKind(itemKind)
    );

    lcdNibbleWriter i_lcdNibbleWriter (
        .clk     (clk),
        .rstN    (rstN),
        .tick    (tick),
        .issue   (issue),
        .itemByte(itemByte),
        .itemKind(itemKind),
        .ready   (ready),
        .lcdE    (lcdE),
        .lcdRs   (lcdRs),
        .lcdData (lcdData)
    );

endmodule

/* source/lcdNibbleWriter.sv */
module lcdNibbleWriter (
    input  logic             clk,
    input  logic             rstN,
    input  logic             tick,
    input  logic             issue,
    input  lcdPkg::byteT     itemByte,
    input  lcdPkg::itemKindT itemKind,
    output logic             ready,
    output logic             lcdE,
    output logic             lcdRs,
    output lcdPkg::nibbleT   lcdData
);
    import lcdPkg::*;

    // three steps per nibble
    typedef enum logic [1:0] {
        phLow,
        phSetup,
        phHigh
    } phaseT;

    phaseT    phase;
    logic     busy;
    logic     secondHalf;
    logic     lastNibble;
    logic     accept;
    byteT     itemReg;
    itemKindT kindReg;
    nibbleT   curNibble;

    assign ready      = !busy;
    assign accept     = tick && ready && issue;
    assign lastNibble = (kindReg == kindWake) || secondHalf;
    // high nibble goes first, wake items carry theirs in the low half
    assign curNibble  = lastNibble ? itemReg[3:0] : itemReg[7:4];

    always_ff @(posedge clk) begin
        if (accept) begin
            itemReg <= itemByte;
            kindReg <= itemKind;
        end
    end

    ////////////////////////////////////////
    // strobe phases
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy       <= 1'b0;
            phase      <= phLow;
            secondHalf <= 1'b0;
            lcdE       <= 1'b0;
            lcdRs      <= 1'b0;
            lcdData    <= '0;
        end else if (tick) begin
            if (!busy) begin
                // low phase of a new item runs on its issue step
                lcdE <= 1'b0;
                if (issue) begin
                    busy       <= 1'b1;
                    phase      <= phSetup;
                    secondHalf <= 1'b0;
                end
            end else begin
                case (phase)
                    phLow: begin
                        lcdE  <= 1'b0;
                        phase <= phSetup;
                    end
                    phSetup: begin
                        lcdRs   <= (kindReg == kindChar);
                        lcdData <= curNibble;
                        phase   <= phHigh;
                    end
                    default: begin
                        lcdE <= 1'b1;
                        if (lastNibble) begin
                            busy  <= 1'b0;
                            phase <= phLow;
                        end else begin
                            secondHalf <= 1'b1;
                            phase      <= phLow;
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* source/lcdPkg.sv */
package lcdPkg;

    ////////////////////////////////////////
    // text geometry
    ////////////////////////////////////////

    localparam int lineChars = 16;
    localparam int lineBits  = lineChars * 8;

    typedef logic [7:0] byteT;
    typedef logic [3:0] nibbleT;

    ////////////////////////////////////////
    // item kinds and sequencer states
    ////////////////////////////////////////

    // wake is a lone nibble, cmd and char are full bytes
    typedef enum logic [1:0] {
        kindWake,
        kindCmd,
        kindChar
    } itemKindT;

    typedef enum logic [2:0] {
        stWake,
        stConfig,
        stAddrA,
        stLineA,
        stAddrB,
        stLineB,
        stGap
    } seqStateT;

    ////////////////////////////////////////
    // HD44780 command codes
    ////////////////////////////////////////

    localparam nibbleT cmdWake        = 4'h3;
    // switches the controller to 4-bit mode
    localparam nibbleT cmdWakeFour    = 4'h2;
    // 4-bit bus, two lines, 5x8 font
    localparam byteT   cmdFunctionSet = 8'h28;
    localparam byteT   cmdEntryMode   = 8'h06;
    localparam byteT   cmdDisplayOn   = 8'h0C;
    localparam byteT   cmdClear       = 8'h01;
    localparam byteT   cmdAddrLineA   = 8'h80;
    localparam byteT   cmdAddrLineB   = 8'hC0;

    // step pacing and idle steps between passes
    localparam int defaultStepCycles = 10001;
    localparam int defaultGapSteps   = 784;

endpackage

/* source/lcdSequencer.sv */
module lcdSequencer #(
    parameter int gapSteps = lcdPkg::defaultGapSteps
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        tick,
    input  logic                        ready,
    input  logic [lcdPkg::lineBits-1:0] lineA,
    input  logic [lcdPkg::lineBits-1:0] lineB,
    output logic                        issue,
    output lcdPkg::byteT                itemByte,
    output lcdPkg::itemKindT            itemKind
);
    import lcdPkg::*;

    localparam int idxW = $clog2(lineChars);
    localparam int gapW = (gapSteps > 1) ? $clog2(gapSteps) : 1;

    localparam logic [idxW-1:0] lastWake   = idxW'(3);
    localparam logic [idxW-1:0] lastConfig = idxW'(3);
    localparam logic [idxW-1:0] lastChar   = idxW'(lineChars - 1);
    localparam logic [gapW-1:0] lastGap    = gapW'(gapSteps - 1);

    seqStateT            state;
    logic [idxW-1:0]     idx;
    logic [gapW-1:0]     gapCnt;
    logic [lineBits-1:0] textA;
    logic [lineBits-1:0] textB;
    logic                step;
    logic                passStart;
    byteT                charA;
    byteT                charB;

    // configuration list in send order
    function automatic byteT configByte(input logic [1:0] sel);
        byteT code;
        case (sel)
            2'd0:    code = cmdFunctionSet;
            2'd1:    code = cmdEntryMode;
            2'd2:    code = cmdDisplayOn;
            default: code = cmdClear;
        endcase
        return code;
    endfunction

    ////////////////////////////////////////
    // issue and item select
    ////////////////////////////////////////

    assign step      = tick && ready;
    assign issue     = step && (state != stGap);
    assign passStart = issue && (state == stWake) && (idx == '0);

    // leftmost character sits in the top byte
    assign charA = textA[lineBits - 8 - 8 * idx +: 8];
    assign charB = textB[lineBits - 8 - 8 * idx +: 8];

    always_comb begin
        itemKind = kindCmd;
        itemByte = '0;
        case (state)
            stWake: begin
                itemKind = kindWake;
                itemByte = {4'h0, (idx == lastWake) ? cmdWakeFour : cmdWake};
            end
            stConfig: begin
                itemByte = configByte(idx[1:0]);
            end
            stAddrA: begin
                itemByte = cmdAddrLineA;
            end
            stLineA: begin
                itemKind = kindChar;
                itemByte = charA;
            end
            stAddrB: begin
                itemByte = cmdAddrLineB;
            end
            stLineB: begin
                itemKind = kindChar;
                itemByte = charB;
            end
            default: begin
                itemByte = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // pass FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= stWake;
            idx    <= '0;
            gapCnt <= '0;
        end else if (step) begin
            case (state)
                stWake: begin
                    if (idx == lastWake) begin
                        state <= stConfig;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                stConfig: begin
                    if (idx == lastConfig) begin
                        state <= stAddrA;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                stAddrA: begin
                    state <= stLineA;
                end
                stLineA: begin
                    if (idx == lastChar) begin
                        state <= stAddrB;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                stAddrB: begin
                    state <= stLineB;
                end
                stLineB: begin
                    if (idx == lastChar) begin
                        state <= (gapSteps == 0) ? stWake : stGap;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    // idle steps, then a fresh pass
                    if (gapCnt == lastGap) begin
                        state  <= stWake;
                        gapCnt <= '0;
                    end else begin
                        gapCnt <= gapCnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // snapshot of both lines for the whole pass
    always_ff @(posedge clk) begin
        if (passStart) begin
            textA <= lineA;
            textB <= lineB;
        end
    end

endmodule

/* source/lcdStepTimer.sv */
module lcdStepTimer #(
    parameter int stepCycles = lcdPkg::defaultStepCycles
) (
    input  logic clk,
    input  logic rstN,
    output logic tick
);

    localparam int cntW = (stepCycles > 1) ? $clog2(stepCycles) : 1;
    localparam logic [cntW-1:0] reloadVal = cntW'(stepCycles - 1);

    logic [cntW-1:0] count;

    // counts down and reloads, one tick per step
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= reloadVal;
        end else if (count == '0) begin
            count <= reloadVal;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign tick = (count == '0);

endmodule

/* tb/lcdCases.txt */
// lineA lineB as 32 hex digits each, leftmost character first
// rand takes both lines from the testbench LFSR
48454C4C4F20574F524C442020202020 48443434373830203442495420425553
6162636465666768696A6B6C6D6E6F70 7172737475767778797A303132333435
00000000000000000000000000000000 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
rand
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 00000000000000000000000000000000
0123456789ABCDEFFEDCBA9876543210 00112233445566778899AABBCCDDEEFF
54454D50202032332E35204320202020 48554D49444954592020343120252020
rand
A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A
80C028060C01033202C0800102030405 0F1E2D3C4B5A69788796A5B4C3D2E1F0
rand
4C494E452041204C4154434845442020 4C494E452042204C4154434845442020
0000000000000000000000000000000F F0000000000000000000000000000000
rand
7E7D7C7B7A797877767574737271706F 2122232425262728292A2B2C2D2E2F30
DEADBEEFCAFEF00D0123456789ABCDEF FEDCBA9876543210F00DCAFEBEEFDEAD
rand
474F4F44425945202020202020202020 20202020202020202020202020202020
31313131313131313131313131313131 32323232323232323232323232323232
rand
48454C4C4F20574F524C442020202020 48443434373830203442495420425553
00000000000000000000000000000000 00000000000000000000000000000001

/* tb/lcdDriverTb.sv */
module lcdDriverTb;

    localparam int stepCycles     = 4;
    localparam int gapSteps       = 6;
    // 4 wake nibbles, then 38 bytes of two nibbles each
    localparam int nibblesPerPass = 4 + 2 * 38;
    localparam int passCycles     = (3 * nibblesPerPass + gapSteps + 3) * stepCycles;

    logic         clk;
    logic         rstN;
    logic [127:0] lineA;
    logic [127:0] lineB;
    logic         lcdE;
    logic         lcdRw;
    logic         lcdRs;
    logic [3:0]   lcdData;

    logic [127:0] caseA[$];
    logic [127:0] caseB[$];
    logic         nibRs[$];
    logic [3:0]   nibData[$];
    int           riseCycle[$];

    logic [31:0]  lfsrState;
    int           errCount;
    int           errMark;
    int           testCount;
    int           failCount;
    logic         timedOut;
    int           cycle;
    int           highCnt;
    int           stableCnt;
    logic         prevE;
    logic [4:0]   prevPins;

    lcdDriver #(
        .stepCycles(stepCycles),
        .gapSteps  (gapSteps)
    ) i_lcdDriver (
        .clk    (clk),
        .rstN   (rstN),
        .lineA  (lineA),
        .lineB  (lineB),
        .lcdE   (lcdE),
        .lcdRw  (lcdRw),
        .lcdRs  (lcdRs),
        .lcdData(lcdData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportMismatch(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errCount++;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount != errMark) begin
            failCount++;
            $display("test %s: failed, %0d errors", name, errCount - errMark);
        end else begin
            $display("test %s: ok", name);
        end
        errMark = errCount;
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic nextLfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] randomLine();
        logic [127:0] line;
        int           k;
        for (k = 0; k < 128; k++) begin
            line = {line[126:0], nextLfsrBit()};
        end
        return line;
    endfunction

    // bytes after the wake nibbles as {rs, byte}
    function automatic logic [8:0] expectedItem(input int idx, input logic [127:0] a,
                                               input logic [127:0] b);
        logic [8:0] item;
        case (idx)
            0:       item = {1'b0, 8'h28};
            1:       item = {1'b0, 8'h06};
            2:       item = {1'b0, 8'h0C};
            3:       item = {1'b0, 8'h01};
            4:       item = {1'b0, 8'h80};
            21:      item = {1'b0, 8'hC0};
            default: begin
                if (idx < 21) begin
                    item = {1'b1, a[127 - 8 * (idx - 5) -: 8]};
                end else begin
                    item = {1'b1, b[127 - 8 * (idx - 22) -: 8]};
                end
            end
        endcase
        return item;
    endfunction

    task automatic readCases();
        int               fd;
        int               code;
        logic [8*96-1:0]  textBuf;
        logic [8*40-1:0]  word;
        logic [127:0]     a;
        logic [127:0]     b;
        fd = $fopen("tb/lcdCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/lcdCases.txt");
            errCount++;
        end else begin
            while (!$feof(fd)) begin
                textBuf = '0;
                word    = '0;
                code    = $fgets(textBuf, fd);
                if (code > 0 && $sscanf(textBuf, "%s", word) == 1) begin
                    if (word == "rand") begin
                        caseA.push_back(randomLine());
                        caseB.push_back(randomLine());
                    end else if (word != "//") begin
                        if ($sscanf(textBuf, "%h %h", a, b) == 2) begin
                            caseA.push_back(a);
                            caseB.push_back(b);
                        end else begin
                            $display("cannot parse case line %0s", textBuf);
                            errCount++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic waitForEdges(input int count);
        int waited;
        waited = 0;
        while (!timedOut && nibRs.size() < count) begin
            if (waited == 2 * passCycles) begin
                $display("timeout: lcdE rising edge %0d not seen after %0d clocks",
                         count, waited);
                errCount++;
                timedOut = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic checkPass(input int passIdx, input logic [127:0] a, input logic [127:0] b);
        int         base;
        int         at;
        int         i;
        int         spacing;
        logic [8:0] want;
        logic [7:0] got;
        base = passIdx * nibblesPerPass;
        for (i = 0; i < 4; i++) begin
            if (nibRs[base + i] !== 1'b0 || nibData[base + i] !== ((i == 3) ? 4'h2 : 4'h3)) begin
                reportMismatch($sformatf("pass %0d wake nibble %0d is rs %b data %h",
                                         passIdx, i, nibRs[base + i], nibData[base + i]));
            end
        end
        for (i = 0; i < 38; i++) begin
            at   = base + 4 + 2 * i;
            want = expectedItem(i, a, b);
            got  = {nibData[at], nibData[at + 1]};
            if (nibRs[at] !== want[8] || nibRs[at + 1] !== want[8] || got !== want[7:0]) begin
                reportMismatch($sformatf("pass %0d byte %0d is rs %b%b %h, expected rs %b %h",
                                         passIdx, i, nibRs[at], nibRs[at + 1], got,
                                         want[8], want[7:0]));
            end
        end
        // nibbles run back to back, three steps apart
        for (i = 1; i < nibblesPerPass; i++) begin
            spacing = riseCycle[base + i] - riseCycle[base + i - 1];
            if (spacing != 3 * stepCycles) begin
                reportMismatch($sformatf("pass %0d edge %0d is %0d clocks after the last",
                                         passIdx, i, spacing));
            end
        end
        if (passIdx > 0) begin
            spacing = riseCycle[base] - riseCycle[base - 1];
            if (spacing != (gapSteps + 3) * stepCycles) begin
                reportMismatch($sformatf("pass %0d starts %0d clocks after the last pass",
                                         passIdx, spacing));
            end
        end
    endtask

    ////////////////////////////////////////
    // pin monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstN) begin
            cycle     = 0;
            prevE     = 1'b0;
            stableCnt = 0;
            prevPins  = {lcdRs, lcdData};
        end else begin
            cycle     = cycle + 1;
            stableCnt = ({lcdRs, lcdData} === prevPins) ? stableCnt + 1 : 0;
            if (lcdRw !== 1'b0) begin
                reportMismatch("lcdRw is not low");
            end
            if (lcdE && !prevE) begin
                if (stableCnt < stepCycles) begin
                    reportMismatch($sformatf("pins stable only %0d clocks before lcdE rise",
                                             stableCnt));
                end
                nibRs.push_back(lcdRs);
                nibData.push_back(lcdData);
                riseCycle.push_back(cycle);
                highCnt = 1;
            end else if (lcdE) begin
                highCnt = highCnt + 1;
                if (stableCnt == 0) begin
                    reportMismatch("lcdRs or lcdData changed while lcdE high");
                end
            end else if (prevE && highCnt != stepCycles) begin
                reportMismatch($sformatf("lcdE high for %0d clocks", highCnt));
            end
            prevE    = lcdE;
            prevPins = {lcdRs, lcdData};
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int i;
        rstN      = 1'b0;
        lineA     = '0;
        lineB     = '0;
        errCount  = 0;
        errMark   = 0;
        testCount = 0;
        failCount = 0;
        timedOut  = 1'b0;
        lfsrState = 32'd94865;
        readCases();
        if (caseA.size() == 0) begin
            $display("no text cases were read");
            errCount++;
        end
        @(posedge clk);
        if (caseA.size() > 0) begin
            lineA <= caseA[0];
            lineB <= caseB[0];
        end
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        if ({lcdE, lcdRs, lcdData, lcdRw} !== 7'b0) begin
            reportMismatch("LCD pins not all low after reset");
        end
        if (i_lcdDriver.issue !== 1'b0 || i_lcdDriver.ready !== 1'b1) begin
            reportMismatch("issue or ready wrong after reset");
        end
        finishTest("reset");
        // next case goes in halfway through a pass
        for (i = 0; i < caseA.size() && !timedOut; i++) begin
            if (i + 1 < caseA.size()) begin
                waitForEdges(i * nibblesPerPass + nibblesPerPass / 2);
                @(posedge clk);
                lineA <= caseA[i + 1];
                lineB <= caseB[i + 1];
            end
            waitForEdges((i + 1) * nibblesPerPass);
            if (!timedOut) begin
                checkPass(i, caseA[i], caseB[i]);
            end
            finishTest($sformatf("case %0d", i));
        end
        $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
